//--- Makefile
# Verilator flow for the scrambled ROM testbench

VERILATOR ?= verilator
TOP       ?= scr_rom_tb
FILELIST  ?= scr_rom.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := === PASS ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/scr_rom_model.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN) rom_init.hex
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/scr_rom_model.svh
////////////////////////////////////////////////////////////////////////////
// Scrambled ROM reference model
// Address scramble, keystream cipher and byte parity rule
////////////////////////////////////////////////////////////////////////////

`ifndef SCR_ROM_MODEL_SVH
`define SCR_ROM_MODEL_SVH

  // PRESENT S-box written out as a lookup
  function automatic logic [3:0] sbox_lookup(input logic [3:0] nib);
    case (nib)
      4'h0: return 4'hc;
      4'h1: return 4'h5;
      4'h2: return 4'h6;
      4'h3: return 4'hb;
      4'h4: return 4'h9;
      4'h5: return 4'h0;
      4'h6: return 4'ha;
      4'h7: return 4'hd;
      4'h8: return 4'h3;
      4'h9: return 4'he;
      4'ha: return 4'hf;
      4'hb: return 4'h8;
      4'hc: return 4'h4;
      4'hd: return 4'h7;
      4'he: return 4'h1;
      default: return 4'h2;
    endcase
  endfunction

  // Two rounds of nonce XOR, S-box, rotate left by one
  function automatic logic [3:0] scramble_addr(input logic [3:0] addr);
    logic [3:0] s;
    s = addr;
    for (int r = 0; r < 2; r++) begin
      s = sbox_lookup(s ^ scr_rom_pkg::SCR_NONCE[63:60]);
      s = {s[2:0], s[3]};
    end
    return s;
  endfunction

  // One cipher round, the target bit steps by 16 modulo 63
  function automatic logic [63:0] spn_round(input logic [63:0] st, input logic [63:0] key);
    logic [63:0] sub;
    logic [63:0] out;
    int          pos;
    for (int n = 0; n < 16; n++) begin
      sub[4*n +: 4] = sbox_lookup(st[4*n +: 4] ^ key[4*n +: 4]);
    end
    pos = 0;
    for (int i = 0; i < 63; i++) begin
      out[pos] = sub[i];
      pos = (pos + 16) % 63;
    end
    out[63] = sub[63];
    return out;
  endfunction

  // Key halves alternate, upper half first
  function automatic logic [63:0] keystream_for(input logic [3:0] tweak);
    logic [63:0] st;
    st = {scr_rom_pkg::SCR_NONCE[59:0], tweak};
    st = spn_round(st, scr_rom_pkg::SCR_KEY[127:64]);
    st = spn_round(st, scr_rom_pkg::SCR_KEY[63:0]);
    st = spn_round(st, scr_rom_pkg::SCR_KEY[127:64]);
    st = spn_round(st, scr_rom_pkg::SCR_KEY[63:0]);
    return st;
  endfunction

  // Even parity per byte, stored bit k sits above the data
  // Four data bytes, so only the low four parity bits are checked
  function automatic logic parity_error_for(input logic [39:0] word);
    logic err;
    err = 1'b0;
    for (int k = 0; k < 4; k++) begin
      err = err | ((^word[8*k +: 8]) != word[32 + k]);
    end
    return err;
  endfunction

`endif

//--- dv/scr_rom_tb.sv
////////////////////////////////////////////////////////////////////////////
// Scrambled ROM testbench
// Table-driven reads compared against the reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_rom_tb;

  `include "scr_rom_model.svh"

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;

  // One table row, gap is the idle cycles after it
  typedef struct {
    string                  name;
    scr_rom_pkg::rom_addr_t addr;
    bit                     req;
    int                     gap;
  } entry_t;

  logic                   clk = 1'b0;
  logic                   reset_i;
  logic                   req_i;
  scr_rom_pkg::rom_addr_t addr_i;
  logic                   rvalid_o;
  scr_rom_pkg::rom_data_t rdata_o;
  scr_rom_pkg::rom_word_t scr_rdata_o;
  logic                   parity_err_o;

  scr_rom_pkg::rom_word_t shadow [scr_rom_pkg::ROM_DEPTH];
  entry_t                 table_q [$];
  logic [31:0]            lfsr_state = 32'h8182_692b;
  int                     check_errors = 0;
  int                     failed_tests = 0;
  int                     errs_base = 0;
  bit                     table_ready = 1'b0;

  // Step driven last cycle, checked on the next one
  bit                     pend_valid = 1'b0;
  int                     pend_idx;
  bit                     pend_req;
  scr_rom_pkg::rom_addr_t pend_addr;
  bit                     pend_first;
  bit                     pend_last;

  scr_rom_top dut_i (
    .clk_i        (clk),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .scr_rdata_o  (scr_rdata_o),
    .parity_err_o (parity_err_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per address bit
  task automatic draw_addr(output scr_rom_pkg::rom_addr_t a);
    for (int b = 0; b < scr_rom_pkg::ROM_AW; b++) begin
      a[b] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic add_entry(input string name, input scr_rom_pkg::rom_addr_t addr,
                           input bit req, input int gap);
    table_q.push_back('{name, addr, req, gap});
  endtask

  task automatic build_table();
    scr_rom_pkg::rom_addr_t a;
    add_entry("idle_after_reset", 4'h0, 1'b0, 3);
    // Every logical address once, spaced by one idle cycle
    for (int i = 0; i < scr_rom_pkg::ROM_DEPTH; i++) begin
      add_entry($sformatf("addr_%0d", i), scr_rom_pkg::rom_addr_t'(i), 1'b1, 1);
    end
    // Back-to-back random reads
    for (int i = 0; i < 8; i++) begin
      draw_addr(a);
      add_entry($sformatf("b2b_%0d", i), a, 1'b1, 0);
    end
    // Random reads with idle gaps
    for (int i = 0; i < 6; i++) begin
      draw_addr(a);
      add_entry($sformatf("gapped_%0d", i), a, 1'b1, 2 + i % 2);
    end
    add_entry("idle_final", 4'h0, 1'b0, 2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_value(input string name, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
    check_errors++;
    $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
  endtask

  // Outputs are all registered, stable one time unit past the edge
  task automatic check_pending();
    string                  name;
    scr_rom_pkg::rom_word_t exp_scr;
    scr_rom_pkg::rom_word_t exp_clr;
    scr_rom_pkg::ks_state_t ks;
    if (!pend_valid) return;
    name = table_q[pend_idx].name;
    if (pend_first) errs_base = check_errors;
    if (pend_req) begin
      exp_scr = shadow[scramble_addr(pend_addr)];
      ks      = keystream_for(pend_addr);
      exp_clr = exp_scr ^ ks[39:0];
      assert (rvalid_o === 1'b1) else report_value(name, "rvalid", 64'd1, 64'(rvalid_o));
      assert (scr_rdata_o === exp_scr)
        else report_value(name, "scr_rdata", 64'(exp_scr), 64'(scr_rdata_o));
      assert (rdata_o === exp_clr[31:0])
        else report_value(name, "rdata", 64'(exp_clr[31:0]), 64'(rdata_o));
      assert (parity_err_o === parity_error_for(exp_clr))
        else report_value(name, "parity_err", 64'(parity_error_for(exp_clr)),
                          64'(parity_err_o));
    end else begin
      assert (rvalid_o === 1'b0) else report_value(name, "rvalid", 64'd0, 64'(rvalid_o));
      assert (parity_err_o === 1'b0)
        else report_value(name, "parity_err", 64'd0, 64'(parity_err_o));
    end
    if (pend_last) begin
      if (check_errors == errs_base) begin
        $display("test %s ok", name);
      end else begin
        failed_tests++;
        $display("test %s had %0d errors", name, check_errors - errs_base);
      end
    end
  endtask

  // Check the previous cycle, then drive this one
  task automatic step(input int idx, input bit req, input scr_rom_pkg::rom_addr_t addr,
                      input bit first, input bit last);
    @(posedge clk);
    #1;
    check_pending();
    req_i      = req;
    addr_i     = addr;
    pend_valid = 1'b1;
    pend_idx   = idx;
    pend_req   = req;
    pend_addr  = addr;
    pend_first = first;
    pend_last  = last;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset_i = 1'b1;
    req_i   = 1'b0;
    addr_i  = '0;
    $readmemh("rom_init.hex", shadow);
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_i = 1'b0;
    foreach (table_q[i]) begin
      step(i, table_q[i].req, table_q[i].addr, 1'b1, table_q[i].gap == 0);
      for (int g = 0; g < table_q[i].gap; g++) begin
        step(i, 1'b0, 4'h0, 1'b0, g == table_q[i].gap - 1);
      end
    end
    // Last drive still owes a check
    @(posedge clk);
    #1;
    check_pending();
    $display("tests %0d, failed %0d, check errors %0d",
             table_q.size(), failed_tests, check_errors);
    if (check_errors == 0 && failed_tests == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Limit from table length times the longest entry
  initial begin
    int     max_gap;
    longint limit_ns;
    wait (table_ready);
    max_gap = 0;
    foreach (table_q[i]) begin
      if (table_q[i].gap > max_gap) max_gap = table_q[i].gap;
    end
    limit_ns = longint'(RESET_CYCLES + table_q.size() * (max_gap + 2) + 20) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- rom_init.hex
// Physical rows 0 to 15, one 40-bit word per line, parity byte then data
5a3c91e07b
e1047fd2a6
0b9e66c4f3
c7d2185a90
93fe0b7c21
2a6d4e8f15
f08c3a91de
6e17b5d248
a4c9f02e6b
18b37ad5c0
d5602f9e87
7f2ba18c34
395ed70a1f
bc81e4f269
04f7c36ba2
e96a2d5013

//--- rtl/rom_addr_scrambler.sv
////////////////////////////////////////////////////////////////////////////
// ROM address scrambler
// Two-round 4-bit SPN giving a fixed bijection from logical to physical row
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_addr_scrambler (
  input  scr_rom_pkg::rom_addr_t addr_i,
  output scr_rom_pkg::rom_addr_t addr_o
);

  // Nonce slice keying every round
  scr_rom_pkg::rom_addr_t addr_nonce;
  // Running state through the rounds
  scr_rom_pkg::rom_addr_t state;

  assign addr_nonce = scr_rom_pkg::SCR_NONCE[63 -: scr_rom_pkg::ROM_AW];

  ////////////////////////////////////////////////////////////////////////////
  // SPN rounds
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state = addr_i;
    for (int r = 0; r < scr_rom_pkg::ADDR_SCR_ROUNDS; r++) begin
      // Key mixing
      state = state ^ addr_nonce;
      // Substitution
      state = scr_rom_pkg::SBOX4[state];
      // Permutation, rotate left by one
      state = {state[scr_rom_pkg::ROM_AW-2:0], state[scr_rom_pkg::ROM_AW-1]};
    end
  end

  // Each step is invertible, so no two rows collide
  assign addr_o = state;

endmodule

//--- rtl/rom_array.sv
////////////////////////////////////////////////////////////////////////////
// ROM storage array
// Sixteen physical words from the init file, one-cycle registered read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_array (
  input logic         clk_i,
  input logic         reset_i,
  rom_rd_if.responder rd
);

  // Init image, already scrambled
  localparam string INIT_FILE = "rom_init.hex";

  // Physical rows
  scr_rom_pkg::rom_word_t mem [scr_rom_pkg::ROM_DEPTH];

  initial begin
    $readmemh(INIT_FILE, mem);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Data holds the last read word between requests
  always_ff @(posedge clk_i) begin
    if (rd.req) begin
      rd.rdata <= mem[rd.addr];
    end
  end

  // Single-cycle read strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd.rvalid <= 1'b0;
    end else begin
      rd.rvalid <= rd.req;
    end
  end

  // No response without a request the cycle before
  rvalid_after_req_a: assert property (@(posedge rd.clk) disable iff (reset_i)
    rd.rvalid |-> $past(rd.req));

endmodule

//--- rtl/rom_keystream_gen.sv
////////////////////////////////////////////////////////////////////////////
// ROM keystream generator
// Four-round 64-bit SPN keyed by the fixed key, register after round two
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_keystream_gen (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  scr_rom_pkg::rom_addr_t tweak_i,
  output logic                   valid_o,
  output scr_rom_pkg::ks_state_t keystream_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Round function
  ////////////////////////////////////////////////////////////////////////////

  // Round index counts from zero, even rounds take the upper key half
  function automatic scr_rom_pkg::ks_state_t ks_round(
    input scr_rom_pkg::ks_state_t state_in,
    input int unsigned            rnd
  );
    scr_rom_pkg::ks_state_t rkey;
    scr_rom_pkg::ks_state_t keyed;
    scr_rom_pkg::ks_state_t subst;
    scr_rom_pkg::ks_state_t perm;
    rkey  = (rnd % 2 == 0) ? scr_rom_pkg::SCR_KEY[127:64] : scr_rom_pkg::SCR_KEY[63:0];
    keyed = state_in ^ rkey;
    // Sixteen parallel S-boxes
    for (int n = 0; n < 16; n++) begin
      subst[4*n +: 4] = scr_rom_pkg::SBOX4[keyed[4*n +: 4]];
    end
    // Bit i lands on 16*i mod 63
    for (int b = 0; b < 63; b++) begin
      perm[(16 * b) % 63] = subst[b];
    end
    // Top bit is a fixed point
    perm[63] = subst[63];
    return perm;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // First half, combinational from the request
  ////////////////////////////////////////////////////////////////////////////

  scr_rom_pkg::ks_state_t half_d;
  scr_rom_pkg::ks_state_t half_q;
  logic                   valid_q;

  always_comb begin
    // Nonce bits above the tweak address
    half_d = {scr_rom_pkg::SCR_NONCE[59:0], tweak_i};
    for (int unsigned r = 0; r < scr_rom_pkg::KS_ROUNDS / 2; r++) begin
      half_d = ks_round(half_d, r);
    end
  end

  // Halfway state, only loaded on a request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      half_q <= half_d;
    end
  end

  // Valid pipeline
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Second half, combinational from the register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    keystream_o = half_q;
    for (int unsigned r = scr_rom_pkg::KS_ROUNDS / 2; r < scr_rom_pkg::KS_ROUNDS; r++) begin
      keystream_o = ks_round(keystream_o, r);
    end
  end

  assign valid_o = valid_q;

  // Keystream lines up with the request one cycle back
  valid_delay_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (valid_o == $past(valid_i)));

endmodule

//--- rtl/rom_parity_check.sv
////////////////////////////////////////////////////////////////////////////
// ROM parity check
// Even byte parity over the clear word, flagged only on valid reads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_parity_check (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   rvalid_i,
  input  scr_rom_pkg::rom_word_t word_i,
  output scr_rom_pkg::rom_data_t rdata_o,
  output logic                   parity_err_o
);

  scr_rom_pkg::rom_par_t            par_stored;
  // One mismatch flag per data byte
  logic [scr_rom_pkg::ROM_DW/8-1:0] par_mismatch;

  // Data in the low bits, parity on top
  assign rdata_o    = word_i[scr_rom_pkg::ROM_DW-1:0];
  assign par_stored = word_i[scr_rom_pkg::ROM_WIDTH-1:scr_rom_pkg::ROM_DW];

  // Bit k must equal the XOR of byte k
  // Only the low parity bits have a data byte behind them
  always_comb begin
    for (int k = 0; k < scr_rom_pkg::ROM_DW / 8; k++) begin
      par_mismatch[k] = (^rdata_o[8*k +: 8]) ^ par_stored[k];
    end
  end

  // Idle cycles never report an error
  assign parity_err_o = rvalid_i & (|par_mismatch);

  // Error strobe stays inside the read strobe
  err_in_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    parity_err_o |-> rvalid_i);

endmodule

//--- rtl/rom_rd_if.sv
////////////////////////////////////////////////////////////////////////////
// ROM read interface
// One read between the scrambling wrapper and the storage array
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface rom_rd_if (
  input logic clk
);

  // Request side
  logic                   req;
  scr_rom_pkg::rom_addr_t addr;

  // Response side, rvalid one cycle after each req
  logic                   rvalid;
  scr_rom_pkg::rom_word_t rdata;

  // Wrapper issues reads
  modport requester (
    input  clk,
    output req,
    output addr,
    input  rvalid,
    input  rdata
  );

  // Storage answers them
  modport responder (
    input  clk,
    input  req,
    input  addr,
    output rvalid,
    output rdata
  );

endinterface

//--- rtl/scr_rom_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Scrambled ROM package
// Word geometry, fixed scrambling key and nonce, S-box and word types
////////////////////////////////////////////////////////////////////////////

package scr_rom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Storage geometry
  ////////////////////////////////////////////////////////////////////////////

  // Number of physical words
  localparam int ROM_DEPTH = 16;
  // Word address width
  localparam int ROM_AW    = 4;
  // Stored word, data plus parity
  localparam int ROM_WIDTH = 40;
  localparam int ROM_DW    = 32;
  // One parity bit per data byte
  localparam int ROM_PW    = 8;

  typedef logic [ROM_AW-1:0]    rom_addr_t;
  typedef logic [ROM_WIDTH-1:0] rom_word_t;
  typedef logic [ROM_DW-1:0]    rom_data_t;
  typedef logic [ROM_PW-1:0]    rom_par_t;

  // Cipher state of the keystream generator
  typedef logic [63:0]          ks_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Scrambling constants
  ////////////////////////////////////////////////////////////////////////////

  // Upper half keys rounds 1 and 3, lower half keys rounds 2 and 4
  localparam logic [127:0] SCR_KEY   = 128'h3a94_c1e7_52b0_8d6f_e41c_7a25_90bd_36f8;

  // Top nibble keys the address SPN, low 60 bits seed the cipher input
  localparam logic [63:0]  SCR_NONCE = 64'h9d2e_5b71_c3a8_064f;

  // PRESENT S-box, entry 0 in the low nibble
  // 0:C 1:5 2:6 3:B 4:9 5:0 6:A 7:D 8:3 9:E A:F B:8 C:4 D:7 E:1 F:2
  localparam logic [15:0][3:0] SBOX4 = 64'h2174_8fe3_da09_b65c;

  // Round counts
  localparam int ADDR_SCR_ROUNDS = 2;
  localparam int KS_ROUNDS       = 4;

endpackage

//--- rtl/scr_rom_top.sv
////////////////////////////////////////////////////////////////////////////
// Scrambled ROM top level
// Scrambled read path followed by the byte parity check
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_rom_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  scr_rom_pkg::rom_addr_t addr_i,
  output logic                   rvalid_o,
  output scr_rom_pkg::rom_data_t rdata_o,
  output scr_rom_pkg::rom_word_t scr_rdata_o,
  output logic                   parity_err_o
);

  scr_rom_pkg::rom_word_t clr_rdata;

  // Same address feeds the row index and the keystream tweak
  scrambled_rom u_scr_rom (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .rom_addr_i   (addr_i),
    .tweak_addr_i (addr_i),
    .rvalid_o     (rvalid_o),
    .scr_rdata_o  (scr_rdata_o),
    .clr_rdata_o  (clr_rdata)
  );

  // Check and strip parity on the clear word
  rom_parity_check u_parity (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rvalid_i     (rvalid_o),
    .word_i       (clr_rdata),
    .rdata_o      (rdata_o),
    .parity_err_o (parity_err_o)
  );

endmodule

//--- rtl/scrambled_rom.sv
////////////////////////////////////////////////////////////////////////////
// Scrambled ROM
// Scrambled row index, address-tweaked keystream and XOR on the read word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scrambled_rom (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  scr_rom_pkg::rom_addr_t rom_addr_i,
  input  scr_rom_pkg::rom_addr_t tweak_addr_i,
  output logic                   rvalid_o,
  output scr_rom_pkg::rom_word_t scr_rdata_o,
  output scr_rom_pkg::rom_word_t clr_rdata_o
);

  scr_rom_pkg::rom_addr_t addr_scr;
  scr_rom_pkg::ks_state_t keystream;
  logic                   ks_valid;

  rom_rd_if rd_if (.clk(clk_i));

  ////////////////////////////////////////////////////////////////////////////
  // Address path
  ////////////////////////////////////////////////////////////////////////////

  // Storage index comes from one address copy only
  rom_addr_scrambler u_addr_scr (
    .addr_i (rom_addr_i),
    .addr_o (addr_scr)
  );

  // Tweak comes from the other copy
  // A fault on either copy alone decrypts to garbage
  rom_keystream_gen u_keystream (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (req_i),
    .tweak_i     (tweak_addr_i),
    .valid_o     (ks_valid),
    .keystream_o (keystream)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Physical storage
  ////////////////////////////////////////////////////////////////////////////

  assign rd_if.req  = req_i;
  assign rd_if.addr = addr_scr;

  rom_array u_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .rd      (rd_if.responder)
  );

  assign rvalid_o    = rd_if.rvalid;
  assign scr_rdata_o = rd_if.rdata;

  // Low keystream bits cover the word, top bits are dropped
  assign clr_rdata_o = rd_if.rdata ^ keystream[scr_rom_pkg::ROM_WIDTH-1:0];

  // Both pipelines carry the same request
  ks_rvalid_match_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ks_valid == rd_if.rvalid);

endmodule

//--- scr_rom.f
+incdir+dv
rtl/scr_rom_pkg.sv
rtl/rom_rd_if.sv
rtl/rom_addr_scrambler.sv
rtl/rom_keystream_gen.sv
rtl/rom_array.sv
rtl/scrambled_rom.sv
rtl/rom_parity_check.sv
rtl/scr_rom_top.sv
dv/scr_rom_tb.sv
